/* hdl/boa_pkg.sv */
// Decode stage shared types
package boa_pkg;

    // Register width.
    localparam int xlen = 32;

    // Major opcodes, instruction bits 6 to 2.
    typedef enum logic [4:0] {
        LOAD     = 5'b00000,
        LOAD_FP  = 5'b00001,
        MISC_MEM = 5'b00011,
        OP_IMM   = 5'b00100,
        AUIPC    = 5'b00101,
        STORE    = 5'b01000,
        STORE_FP = 5'b01001,
        AMO      = 5'b01011,
        OP       = 5'b01100,
        LUI      = 5'b01101,
        MADD     = 5'b10000,
        MSUB     = 5'b10001,
        NMSUB    = 5'b10010,
        NMADD    = 5'b10011,
        OP_FP    = 5'b10100,
        BRANCH   = 5'b11000,
        JALR     = 5'b11001,
        JAL      = 5'b11011,
        SYSTEM   = 5'b11100
    } rv_opcode_e;

    // ALU funct3 values that need extra field checks.
    typedef enum logic [2:0] {
        ADD = 3'b000,
        SLL = 3'b001,
        SRL = 3'b101
    } rv_alu_e;

    // Trap cause for an unrecognised instruction.
    localparam logic [3:0] cause_illegal_insn = 4'd2;

    // Fetch to decode.
    typedef struct packed {
        logic            valid;
        logic [31:1]     pc;
        logic [31:0]     insn;
        logic            trap;
        logic [3:0]      cause;
    } fetch_t;

    // Decode to execute.
    typedef struct packed {
        logic            valid;
        logic [31:1]     pc;
        logic [31:0]     insn;
        logic            use_rd;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
        logic            branch;
        logic            branch_predict;
        logic            trap;
        logic [3:0]      cause;
    } decode_out_t;

    // Register write-back port.
    typedef struct packed {
        logic            we;
        logic [4:0]      rd;
        logic [xlen-1:0] wdata;
    } writeback_t;

    // Branch report back to fetch.
    typedef struct packed {
        logic            is_xret;
        logic            is_jump;
        logic            is_branch;
        logic            predict;
        logic            use_rs1;
        logic [31:1]     target;
    } branch_info_t;

endpackage

/* hdl/boa_regfile.sv */
// Integer register file
`timescale 1ns/1ps

module boa_regfile (
    input  logic                      clk,
    input  logic                      rst,
    input  boa_pkg::writeback_t       wb,
    input  logic [4:0]                rs1,
    input  logic [4:0]                rs2,
    output logic [boa_pkg::xlen-1:0]  rs1_val,
    output logic [boa_pkg::xlen-1:0]  rs2_val
);

    // x0 has no storage.
    logic [boa_pkg::xlen-1:0] regs [31:1];

    // Combinational read, so a same-cycle write is not seen yet.
    always_comb begin
        rs1_val = '0;
        rs2_val = '0;
        if (rs1 != 5'd0) begin
            rs1_val = regs[rs1];
        end
        if (rs2 != 5'd0) begin
            rs2_val = regs[rs2];
        end
    end

    // Write port.
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.we && (wb.rd != 5'd0)) begin
            regs[wb.rd] <= wb.wdata;
        end
    end

endmodule

/* hdl/boa_insn_decoder.sv */
// RV32 instruction decoder
`timescale 1ns/1ps

module boa_insn_decoder #(
    parameter bit has_m = 1'b1
) (
    input  logic [31:0] insn,
    output logic        recognised,
    output logic        use_rd
);

    boa_pkg::rv_opcode_e opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic                valid_op_imm;
    logic                valid_op;
    logic                valid_system;

    assign opcode = boa_pkg::rv_opcode_e'(insn[6:2]);
    assign funct3 = insn[14:12];
    assign funct7 = insn[31:25];

    // OP-IMM checks, shift amounts are only 5 bits wide on RV32.
    always_comb begin
        if (funct3 == boa_pkg::SLL) begin
            valid_op_imm = (funct7 == 7'd0);
        end else if (funct3 == boa_pkg::SRL) begin
            // SRLI or SRAI.
            valid_op_imm = (insn[31] == 1'b0) && (insn[29:25] == 5'd0);
        end else begin
            valid_op_imm = 1'b1;
        end
    end

    // OP checks on funct7.
    always_comb begin
        case (funct7)
            7'd0: begin
                valid_op = 1'b1;
            end
            7'd1: begin
                // Multiply and divide.
                valid_op = has_m;
            end
            7'd32: begin
                // SUB and SRA only.
                valid_op = (funct3 == boa_pkg::ADD) || (funct3 == boa_pkg::SRL);
            end
            default: begin
                valid_op = 1'b0;
            end
        endcase
    end

    // SYSTEM checks.
    always_comb begin
        if (funct3 == 3'b000) begin
            // Privileged forms, rs1 and rd must be zero.
            case (insn[31:7])
                {12'h000, 13'd0}: valid_system = 1'b1;
                {12'h001, 13'd0}: valid_system = 1'b1;
                {12'h302, 13'd0}: valid_system = 1'b1;
                {12'h105, 13'd0}: valid_system = 1'b1;
                default:          valid_system = 1'b0;
            endcase
        end else begin
            // CSR access.
            valid_system = (funct3 != 3'b100);
        end
    end

    // Per-opcode validity.
    always_comb begin
        recognised = 1'b0;
        if (insn[1:0] == 2'b11) begin
            case (opcode)
                boa_pkg::LOAD: begin
                    recognised = (funct3 != 3'd3) && (funct3 < 3'd6);
                end
                boa_pkg::MISC_MEM: begin
                    // FENCE or FENCE.I.
                    recognised = (funct3[2:1] == 2'b00);
                end
                boa_pkg::OP_IMM: recognised = valid_op_imm;
                boa_pkg::AUIPC:  recognised = 1'b1;
                boa_pkg::STORE: begin
                    recognised = (funct3 <= 3'd2);
                end
                boa_pkg::OP:     recognised = valid_op;
                boa_pkg::LUI:    recognised = 1'b1;
                boa_pkg::BRANCH: begin
                    recognised = (funct3 != 3'd2) && (funct3 != 3'd3);
                end
                boa_pkg::JALR: begin
                    recognised = (funct3 == 3'd0);
                end
                boa_pkg::JAL:    recognised = 1'b1;
                boa_pkg::SYSTEM: recognised = valid_system;
                // No float or atomic support.
                boa_pkg::LOAD_FP,
                boa_pkg::STORE_FP,
                boa_pkg::AMO,
                boa_pkg::MADD,
                boa_pkg::MSUB,
                boa_pkg::NMSUB,
                boa_pkg::NMADD,
                boa_pkg::OP_FP: begin
                    recognised = 1'b0;
                end
                default: begin
                    recognised = 1'b0;
                end
            endcase
        end
    end

    // Destination register use.
    always_comb begin
        case (opcode)
            boa_pkg::LOAD,
            boa_pkg::OP_IMM,
            boa_pkg::AUIPC,
            boa_pkg::OP,
            boa_pkg::LUI,
            boa_pkg::JALR,
            boa_pkg::JAL: begin
                use_rd = 1'b1;
            end
            boa_pkg::SYSTEM: begin
                use_rd = (funct3 != 3'b000);
            end
            default: begin
                use_rd = 1'b0;
            end
        endcase
    end

endmodule

/* hdl/boa_branch_unit.sv */
// Branch target unit
`timescale 1ns/1ps

module boa_branch_unit (
    input  logic [31:0]               insn,
    input  logic [31:1]               pc,
    input  logic [boa_pkg::xlen-1:0]  rs1_val,
    output boa_pkg::branch_info_t     info
);

    boa_pkg::rv_opcode_e opcode;
    logic [31:0]         imm_j;
    logic [31:0]         imm_b;
    logic [31:0]         imm_i;
    logic [31:0]         add_lhs;
    logic [31:0]         add_rhs;
    logic [31:0]         add_res;

    assign opcode = boa_pkg::rv_opcode_e'(insn[6:2]);

    // Sign-extended immediates.
    assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    assign imm_i = {{20{insn[31]}}, insn[31:20]};

    // Adder operand select.
    always_comb begin
        case (opcode)
            boa_pkg::JAL: begin
                add_lhs = {pc, 1'b0};
                add_rhs = imm_j;
            end
            boa_pkg::BRANCH: begin
                add_lhs = {pc, 1'b0};
                add_rhs = imm_b;
            end
            boa_pkg::JALR: begin
                add_lhs = rs1_val;
                add_rhs = imm_i;
            end
            default: begin
                add_lhs = {pc, 1'b0};
                add_rhs = '0;
            end
        endcase
    end

    assign add_res = add_lhs + add_rhs;

    // Classification.
    always_comb begin
        info           = '0;
        info.target    = add_res[31:1];
        // Static prediction from the offset sign.
        info.predict   = insn[31];
        info.is_jump   = (opcode == boa_pkg::JAL) || (opcode == boa_pkg::JALR);
        info.is_branch = (opcode == boa_pkg::BRANCH);
        info.use_rs1   = (opcode == boa_pkg::JALR);
        // MRET pattern.
        info.is_xret   = (opcode == boa_pkg::SYSTEM) && insn[21] && insn[28];
    end

endmodule

/* hdl/boa_stage_id.sv */
// Instruction decode stage
`timescale 1ns/1ps

module boa_stage_id #(
    parameter bit has_m = 1'b1
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      clear,
    input  logic                      stall,
    input  boa_pkg::fetch_t           fetch,
    input  boa_pkg::writeback_t       wb,
    input  logic                      fw_rs1,
    input  logic [boa_pkg::xlen-1:0]  fw_val,
    output boa_pkg::decode_out_t      decoded,
    output boa_pkg::branch_info_t     branch
);

    boa_pkg::fetch_t          bar;
    logic [boa_pkg::xlen-1:0] rs1_val;
    logic [boa_pkg::xlen-1:0] rs2_val;
    logic [boa_pkg::xlen-1:0] bu_rs1_val;
    logic                     recognised;
    logic                     use_rd;

    // Pipeline barrier, held while stalled.
    always_ff @(posedge clk) begin
        if (rst) begin
            bar.valid <= 1'b0;
            bar.trap  <= 1'b0;
        end else if (!stall) begin
            bar <= fetch;
        end
    end

    boa_regfile i_regfile (
        .clk     (clk),
        .rst     (rst),
        .wb      (wb),
        .rs1     (bar.insn[19:15]),
        .rs2     (bar.insn[24:20]),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    boa_insn_decoder #(
        .has_m (has_m)
    ) i_decoder (
        .insn       (bar.insn),
        .recognised (recognised),
        .use_rd     (use_rd)
    );

    // Forwarded RS1 for JALR.
    assign bu_rs1_val = fw_rs1 ? fw_val : rs1_val;

    boa_branch_unit i_branch_unit (
        .insn    (bar.insn),
        .pc      (bar.pc),
        .rs1_val (bu_rs1_val),
        .info    (branch)
    );

    // Output to execute.
    always_comb begin
        decoded                = '0;
        decoded.pc             = bar.pc;
        decoded.insn           = bar.insn;
        decoded.use_rd         = use_rd;
        decoded.rs1_val        = rs1_val;
        decoded.rs2_val        = rs2_val;
        decoded.branch         = branch.is_branch;
        decoded.branch_predict = branch.predict;
        decoded.valid          = bar.valid && recognised && !clear;
        // Fetch traps take priority over decode errors.
        decoded.trap           = !clear && (bar.trap || (bar.valid && !recognised));
        decoded.cause          = bar.trap ? bar.cause : boa_pkg::cause_illegal_insn;
    end

endmodule

/* tests/boa_stage_id_checks.svh */
// Decode stage compare tasks
`ifndef BOA_STAGE_ID_CHECKS_SVH
`define BOA_STAGE_ID_CHECKS_SVH

int mismatch_count = 0;
int failure_count  = 0;

// Whole output struct to execute.
task automatic check_decoded(input boa_pkg::decode_out_t got,
                             input boa_pkg::decode_out_t exp);
    if (got !== exp) begin
        mismatch_count++;
        $display("Mismatch at %0t: decoded got %h expected %h", $time, got, exp);
        $display("  valid %b/%b trap %b/%b cause %h/%h use_rd %b/%b",
                 got.valid, exp.valid, got.trap, exp.trap,
                 got.cause, exp.cause, got.use_rd, exp.use_rd);
        $display("  rs1_val %h/%h rs2_val %h/%h",
                 got.rs1_val, exp.rs1_val, got.rs2_val, exp.rs2_val);
    end
endtask

// Branch report to fetch.
task automatic check_branch(input boa_pkg::branch_info_t got,
                            input boa_pkg::branch_info_t exp);
    if (got !== exp) begin
        mismatch_count++;
        $display("Mismatch at %0t: branch got %h expected %h", $time, got, exp);
        $display("  target %h/%h", {got.target, 1'b0}, {exp.target, 1'b0});
    end
endtask

// Register read values.
task automatic check_reg(input logic [boa_pkg::xlen-1:0] got,
                         input logic [boa_pkg::xlen-1:0] exp,
                         input string name);
    if (got !== exp) begin
        mismatch_count++;
        $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
endtask

// Single status flags.
task automatic check_bit(input logic got, input logic exp, input string name);
    if (got !== exp) begin
        mismatch_count++;
        $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    end
endtask

`endif

/* tests/boa_stage_id_tb.sv */
// Decode stage testbench
`timescale 1ns/1ps

module boa_stage_id_tb;

    localparam int reset_cycles = 2;

    // One line of the vector file.
    typedef struct packed {
        logic        fvalid;
        logic [31:0] pc;
        logic [31:0] insn;
        logic        ftrap;
        logic [3:0]  fcause;
        logic        stall;
        logic        clear;
        logic        fw_rs1;
        logic [31:0] fw_val;
        logic        valid;
        logic        trap;
        logic [3:0]  cause;
        logic        use_rd;
        logic        is_xret;
        logic        is_jump;
        logic        is_branch;
        logic        predict;
        logic        use_rs1;
        logic [31:0] target;
    } vector_t;

    logic                  clk;
    logic                  rst;
    logic                  clear;
    logic                  stall;
    boa_pkg::fetch_t       fetch;
    boa_pkg::writeback_t   wb;
    logic                  fw_rs1;
    logic [31:0]           fw_val;
    boa_pkg::decode_out_t  decoded;
    boa_pkg::branch_info_t branch;

    vector_t         vectors[$];
    logic [31:0]     model [32];
    logic [31:0]     rand_state;
    boa_pkg::fetch_t held;
    int              cycle_count = 0;
    int              cycle_limit = reset_cycles + 31 + 20;

    `include "boa_stage_id_checks.svh"

    boa_stage_id #(
        .has_m (1'b1)
    ) i_dut (
        .clk     (clk),
        .rst     (rst),
        .clear   (clear),
        .stall   (stall),
        .fetch   (fetch),
        .wb      (wb),
        .fw_rs1  (fw_rs1),
        .fw_val  (fw_val),
        .decoded (decoded),
        .branch  (branch)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Run limit grows once the vectors are loaded.
    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, the test sequence did not complete",
                     cycle_count);
            failure_count++;
            finish_run();
            $finish;
        end
    end

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    // ADD x0, rs1, rs2 just to steer the read ports.
    function automatic logic [31:0] read_insn(input logic [4:0] rs1, input logic [4:0] rs2);
        return {7'd0, rs2, rs1, 3'd0, 5'd0, 7'h33};
    endfunction

    task automatic read_vectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] c [19];
        vector_t     v;
        fd = $fopen("tests/boa_stage_id_vectors.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file tests/boa_stage_id_vectors.txt");
            failure_count++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7], c[8], c[9],
                        c[10], c[11], c[12], c[13], c[14], c[15], c[16], c[17], c[18]);
            if (n == 19) begin
                v = {c[0][0], c[1], c[2], c[3][0], c[4][3:0], c[5][0], c[6][0], c[7][0],
                     c[8], c[9][0], c[10][0], c[11][3:0], c[12][0], c[13][0], c[14][0],
                     c[15][0], c[16][0], c[17][0], c[18]};
                vectors.push_back(v);
            end
        end
        $fclose(fd);
        if (vectors.size() == 0) begin
            $display("The vector file holds no usable vectors");
            failure_count++;
        end
    endtask

    // Reset read-back and one write per register.
    task automatic fill_registers();
        fetch       = '0;
        fetch.valid = 1'b1;
        fetch.insn  = read_insn(5'd1, 5'd0);
        @(posedge clk);
        #1;
        check_reg(decoded.rs1_val, 32'd0, "rs1_val");
        check_reg(decoded.rs2_val, 32'd0, "rs2_val");
        #1;
        for (int k = 1; k < 32; k++) begin
            model[k]   = next_random();
            wb.we      = 1'b1;
            wb.rd      = 5'(k);
            wb.wdata   = model[k];
            fetch.insn = read_insn(5'(k), 5'(k + 1));
            @(posedge clk);
            #1;
            // rs2 points at a register that is not written yet.
            check_reg(decoded.rs1_val, model[k], "rs1_val");
            check_reg(decoded.rs2_val, 32'd0, "rs2_val");
            #1;
        end
        wb.rd      = 5'd0;
        wb.wdata   = next_random();
        fetch.insn = read_insn(5'd0, 5'd0);
        @(posedge clk);
        #1;
        check_reg(decoded.rs1_val, 32'd0, "rs1_val");
        check_reg(decoded.rs2_val, 32'd0, "rs2_val");
        #1;
        wb = '0;
    endtask

    task automatic run_vectors();
        vector_t               v;
        boa_pkg::decode_out_t  exp_dec;
        boa_pkg::branch_info_t exp_br;
        boa_pkg::branch_info_t got_br;
        logic [31:0]           sum;
        for (int i = 0; i < vectors.size(); i++) begin
            v           = vectors[i];
            fetch.valid = v.fvalid;
            fetch.pc    = v.pc[31:1];
            fetch.insn  = v.insn;
            fetch.trap  = v.ftrap;
            fetch.cause = v.fcause;
            stall       = v.stall;
            clear       = v.clear;
            fw_rs1      = v.fw_rs1;
            fw_val      = v.fw_val;
            // Barrier model.
            if (!v.stall) begin
                held = fetch;
            end
            exp_dec.valid          = v.valid;
            exp_dec.pc             = held.pc;
            exp_dec.insn           = held.insn;
            exp_dec.use_rd         = v.use_rd;
            exp_dec.rs1_val        = model[held.insn[19:15]];
            exp_dec.rs2_val        = model[held.insn[24:20]];
            exp_dec.branch         = v.is_branch;
            exp_dec.branch_predict = v.predict;
            exp_dec.trap           = v.trap;
            exp_dec.cause          = v.cause;
            exp_br.is_xret   = v.is_xret;
            exp_br.is_jump   = v.is_jump;
            exp_br.is_branch = v.is_branch;
            exp_br.predict   = v.predict;
            exp_br.use_rs1   = v.use_rs1;
            // JALR target from the register model plus the I immediate.
            if (v.use_rs1 && !v.fw_rs1) begin
                sum = model[held.insn[19:15]] + {{20{held.insn[31]}}, held.insn[31:20]};
            end else begin
                sum = v.target;
            end
            exp_br.target = sum[31:1];
            @(posedge clk);
            #1;
            got_br = branch;
            // Target only means something for jumps and branches.
            if (!(v.is_jump || v.is_branch)) begin
                got_br.target = '0;
                exp_br.target = '0;
            end
            check_decoded(decoded, exp_dec);
            check_branch(got_br, exp_br);
            #1;
        end
        stall = 1'b0;
        clear = 1'b0;
    endtask

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if ((mismatch_count == 0) && (failure_count == 0)) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
    endtask

    initial begin
        rst        = 1'b1;
        clear      = 1'b0;
        stall      = 1'b0;
        fetch      = '0;
        wb         = '0;
        fw_rs1     = 1'b0;
        fw_val     = '0;
        held       = '0;
        rand_state = 32'd41072;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        read_vectors();
        cycle_limit = cycle_limit + 2 * vectors.size();
        repeat (reset_cycles) @(posedge clk);
        #2;
        rst = 1'b0;
        if (failure_count == 0) begin
            check_bit(decoded.valid, 1'b0, "decoded.valid");
            check_bit(decoded.trap, 1'b0, "decoded.trap");
            fill_registers();
            run_vectors();
        end
        finish_run();
        $finish;
    end

endmodule

/* boa_stage_id.f */
+incdir+tests
hdl/boa_pkg.sv
hdl/boa_regfile.sv
hdl/boa_insn_decoder.sv
hdl/boa_branch_unit.sv
hdl/boa_stage_id.sv
tests/boa_stage_id_tb.sv

/* run.sh */
#!/bin/sh
# Build the decode stage testbench with Verilator, run it and scan the log.
rm -rf obj_dir sim.log
verilator --binary --timing -f boa_stage_id.f --top-module boa_stage_id_tb \
    -o boa_stage_id_sim \
    && ./obj_dir/boa_stage_id_sim > sim.log 2>&1 \
    || { echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation reported failure"; exit 1; }
echo "Simulation finished without failures"
exit 0

/* tests/boa_stage_id_vectors.txt */
// fvalid pc insn ftrap fcause stall clear fw_rs1 fw_val, then expected
// valid trap cause use_rd is_xret is_jump is_branch predict use_rs1 target (hex)
1 00000100 00510093 0 0 0 0 0 00000000 1 0 2 1 0 0 0 0 0 00000000
1 00000104 005201B3 0 0 0 0 0 00000000 1 0 2 1 0 0 0 0 0 00000000
1 00000108 405201B3 0 0 0 0 0 00000000 1 0 2 1 0 0 0 0 0 00000000
1 0000010C 405251B3 0 0 0 0 0 00000000 1 0 2 1 0 0 0 0 0 00000000
1 00000110 02838333 0 0 0 0 0 00000000 1 0 2 1 0 0 0 0 0 00000000
1 00000114 065201B3 0 0 0 0 0 00000000 0 1 2 1 0 0 0 0 0 00000000
1 00000118 00311093 0 0 0 0 0 00000000 1 0 2 1 0 0 0 0 0 00000000
1 0000011C 02311093 0 0 0 0 0 00000000 0 1 2 1 0 0 0 0 0 00000000
1 00000120 40315093 0 0 0 0 0 00000000 1 0 2 1 0 0 0 0 0 00000000
1 00000124 00852483 0 0 0 0 0 00000000 1 0 2 1 0 0 0 0 0 00000000
1 00000128 00853483 0 0 0 0 0 00000000 0 1 2 1 0 0 0 0 0 00000000
1 0000012C 00B62623 0 0 0 0 0 00000000 1 0 2 0 0 0 0 0 0 00000000
1 00000130 123452B7 0 0 0 0 0 00000000 1 0 2 1 0 0 0 0 0 00000000
1 00000134 00001317 0 0 0 0 0 00000000 1 0 2 1 0 0 0 0 0 00000000
1 00000138 0FF0000F 0 0 0 0 0 00000000 1 0 2 0 0 0 0 0 0 00000000
1 0000013C 00000073 0 0 0 0 0 00000000 1 0 2 0 0 0 0 0 0 00000000
1 00000140 00100073 0 0 0 0 0 00000000 1 0 2 0 0 0 0 0 0 00000000
1 00000144 30200073 0 0 0 0 0 00000000 1 0 2 0 1 0 0 0 0 00000000
1 00000148 10500073 0 0 0 0 0 00000000 1 0 2 0 0 0 0 0 0 00000000
1 0000014C 10200073 0 0 0 0 0 00000000 0 1 2 0 1 0 0 0 0 00000000
1 00000150 340110F3 0 0 0 0 0 00000000 1 0 2 1 0 0 0 0 0 00000000
1 00000154 340140F3 0 0 0 0 0 00000000 0 1 2 1 0 0 0 0 0 00000000
1 00000158 003100D3 0 0 0 0 0 00000000 0 1 2 0 0 0 0 0 0 00000000
1 00001000 010000EF 0 0 0 0 0 00000000 1 0 2 1 0 1 0 0 0 00001010
1 00002000 FF9FF06F 0 0 0 0 0 00000000 1 0 2 1 0 1 0 1 0 00001FF8
1 00003000 00208463 0 0 0 0 0 00000000 1 0 2 0 0 0 1 0 0 00003008
1 00003000 FE209EE3 0 0 0 0 0 00000000 1 0 2 0 0 0 1 1 0 00002FFC
1 00003004 0020A463 0 0 0 0 0 00000000 0 1 2 0 0 0 1 0 0 0000300C
1 00004000 004280E7 0 0 0 0 0 00000000 1 0 2 1 0 1 0 0 1 00000000
1 00004000 004280E7 0 0 0 0 1 00008000 1 0 2 1 0 1 0 0 1 00008004
1 00004004 FFC300E7 0 0 0 0 0 00000000 1 0 2 1 0 1 0 1 1 00000000
1 00004004 FFC300E7 0 0 0 0 1 12345679 1 0 2 1 0 1 0 1 1 12345674
1 00004008 004290E7 0 0 0 0 0 00000000 0 1 2 1 0 1 0 0 1 00000000
0 00000200 00000013 1 1 0 0 0 00000000 0 1 1 1 0 0 0 0 0 00000000
0 00000204 005201B3 0 0 0 0 0 00000000 0 0 2 1 0 0 0 0 0 00000000
1 00000208 00510093 0 0 0 0 0 00000000 1 0 2 1 0 0 0 0 0 00000000
1 0000020C FFFFFFFF 0 0 1 0 0 00000000 1 0 2 1 0 0 0 0 0 00000000
1 00000210 00000073 0 0 1 1 0 00000000 0 0 2 1 0 0 0 0 0 00000000
1 00000210 00B62623 0 0 0 0 0 00000000 1 0 2 0 0 0 0 0 0 00000000
0 00000214 00000013 1 5 0 1 0 00000000 0 0 5 1 0 0 0 0 0 00000000
1 00000218 065201B3 0 0 0 1 0 00000000 0 0 2 1 0 0 0 0 0 00000000
1 00005000 010000EF 0 0 0 0 0 00000000 1 0 2 1 0 1 0 0 0 00005010
1 00005004 00208463 0 0 1 0 0 00000000 1 0 2 1 0 1 0 0 0 00005010
1 00006000 004280E7 0 0 0 0 0 00000000 1 0 2 1 0 1 0 0 1 00000000
1 00006004 00000073 0 0 1 0 1 00000100 1 0 2 1 0 1 0 0 1 00000104
